/* design/axis_if.sv */
/*
 * Converged stream interface
 */

`timescale 1ns/10ps

interface axis_if;
    import mpls_bus_pkg::*;

    conv_data_t data;
    conv_keep_t keep;
    logic       last;
    logic       valid;
    logic       ready;

    // Producer side
    modport source (
        output data,
        output keep,
        output last,
        output valid,
        input  ready
    );

    // Consumer side
    modport sink (
        input  data,
        input  keep,
        input  last,
        input  valid,
        output ready
    );

endinterface

/* design/ing_frame_fifo.sv */
/*
 * Store and forward frame buffer
 */

`timescale 1ns/10ps

module ing_frame_fifo (
    input  logic   clk,
    input  logic   rst,
    axis_if.sink   wr,
    axis_if.source rd,
    output logic   overflow
);
    import mpls_bus_pkg::*;
    import mpls_ingress_pkg::*;

    // Frame storage
    conv_data_t mem_data [FIFO_DEPTH];
    conv_keep_t mem_keep [FIFO_DEPTH];
    logic       mem_last [FIFO_DEPTH];

    // Write head, end of last whole frame, read head
    fifo_ptr_t wr_ptr;
    fifo_ptr_t commit_ptr;
    fifo_ptr_t rd_ptr;

    // Rest of the current frame is thrown away
    logic drop;

    logic full;
    logic wr_accept;
    logic wr_store;
    logic rd_accept;

    ////////////////////////////////////////
    // Write side

    // Never back-pressure the port
    assign wr.ready = 1'b1;

    assign full = (wr_ptr[FIFO_ADDR_BITS] != rd_ptr[FIFO_ADDR_BITS]) &&
                  (wr_ptr[FIFO_ADDR_BITS-1:0] == rd_ptr[FIFO_ADDR_BITS-1:0]);

    assign wr_accept = wr.valid && wr.ready;
    assign wr_store  = wr_accept && !drop && !full;

    // First beat that finds the buffer full
    assign overflow = wr_accept && !drop && full;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            drop       <= 1'b0;
        end else if (wr_accept) begin
            if (drop) begin
                if (wr.last) begin
                    drop <= 1'b0;
                end
            end else if (full) begin
                // Undo the partial frame
                wr_ptr <= commit_ptr;
                drop   <= !wr.last;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
                if (wr.last) begin
                    commit_ptr <= wr_ptr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_store) begin
            mem_data[wr_ptr[FIFO_ADDR_BITS-1:0]] <= wr.data;
            mem_keep[wr_ptr[FIFO_ADDR_BITS-1:0]] <= wr.keep;
            mem_last[wr_ptr[FIFO_ADDR_BITS-1:0]] <= wr.last;
        end
    end

    ////////////////////////////////////////
    // Read side

    // Only committed frames are visible
    assign rd.valid = (rd_ptr != commit_ptr);
    assign rd.data  = mem_data[rd_ptr[FIFO_ADDR_BITS-1:0]];
    assign rd.keep  = mem_keep[rd_ptr[FIFO_ADDR_BITS-1:0]];
    assign rd.last  = mem_last[rd_ptr[FIFO_ADDR_BITS-1:0]];

    assign rd_accept = rd.valid && rd.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (rd_accept) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

/* design/ing_port_arbiter.sv */
/*
 * Round robin frame merge
 */

`timescale 1ns/10ps

module ing_port_arbiter (
    input  logic                       clk,
    input  logic                       rst,
    axis_if.sink                       ports_in [mpls_ingress_pkg::NUM_PORTS],
    output mpls_bus_pkg::conv_data_t   conv_tdata,
    output mpls_bus_pkg::conv_keep_t   conv_tkeep,
    output logic                       conv_tlast,
    output logic                       conv_tvalid,
    input  logic                       conv_tready,
    output mpls_ingress_pkg::port_idx_t conv_port
);
    import mpls_bus_pkg::*;
    import mpls_ingress_pkg::*;

    // Flattened view of the buffer outputs
    conv_data_t           in_data [NUM_PORTS];
    conv_keep_t           in_keep [NUM_PORTS];
    logic [NUM_PORTS-1:0] in_last;
    logic [NUM_PORTS-1:0] in_valid;
    logic [NUM_PORTS-1:0] in_ready;

    arb_state_t state;
    port_idx_t  rr_ptr;
    port_idx_t  grant;
    port_idx_t  pick;
    port_idx_t  cur_port;
    logic       found;
    logic       active;
    logic       beat_done;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        assign in_data[p]        = ports_in[p].data;
        assign in_keep[p]        = ports_in[p].keep;
        assign in_last[p]        = ports_in[p].last;
        assign in_valid[p]       = ports_in[p].valid;
        assign ports_in[p].ready = in_ready[p];
    end

    ////////////////////////////////////////
    // Round robin search

    // Start from the port after the last winner
    always_comb begin
        port_idx_t cand;
        found = 1'b0;
        pick  = rr_ptr;
        for (int i = 0; i < NUM_PORTS; i++) begin
            cand = port_idx_t'(rr_ptr + i);
            if (!found && in_valid[cand]) begin
                found = 1'b1;
                pick  = cand;
            end
        end
    end

    ////////////////////////////////////////
    // Routing

    assign cur_port = (state == ARB_IDLE) ? pick : grant;
    assign active   = (state == ARB_FRAME) || found;

    assign conv_tvalid = active && in_valid[cur_port];
    assign conv_tdata  = in_data[cur_port];
    assign conv_tkeep  = in_keep[cur_port];
    assign conv_tlast  = in_last[cur_port];
    assign conv_port   = cur_port;

    assign beat_done = conv_tvalid && conv_tready;

    // Ready only to the granted buffer
    always_comb begin
        in_ready           = '0;
        in_ready[cur_port] = active && conv_tready;
    end

    ////////////////////////////////////////
    // Grant FSM

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ARB_IDLE;
            rr_ptr <= '0;
            grant  <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (found) begin
                        grant <= pick;
                        // Single beat frames finish without leaving idle
                        if (beat_done && conv_tlast) begin
                            rr_ptr <= pick + 1'b1;
                        end else begin
                            state <= ARB_FRAME;
                        end
                    end
                end
                ARB_FRAME: begin
                    if (beat_done && conv_tlast) begin
                        state  <= ARB_IDLE;
                        rr_ptr <= grant + 1'b1;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

endmodule

/* design/ing_width_upsizer.sv */
/*
 * Port to converged width upsizer
 */

`timescale 1ns/10ps

module ing_width_upsizer (
    input  logic                    clk,
    input  logic                    rst,
    input  mpls_bus_pkg::port_data_t in_data,
    input  mpls_bus_pkg::port_keep_t in_keep,
    input  logic                    in_last,
    input  logic                    in_valid,
    output logic                    in_ready,
    axis_if.source                  out
);
    import mpls_bus_pkg::*;

    // Lower lane held until its partner beat arrives
    port_data_t lo_data;
    port_keep_t lo_keep;

    // High while the lower lane is filled
    logic phase;
    logic in_accept;
    logic load_out;

    ////////////////////////////////////////
    // Handshake

    // One deep output stage refilled as it drains
    assign in_ready  = !out.valid || out.ready;
    assign in_accept = in_valid && in_ready;

    // Word complete on the upper lane or on an odd last beat
    assign load_out = in_accept && (phase || in_last);

    ////////////////////////////////////////
    // Control

    always_ff @(posedge clk) begin
        if (rst) begin
            phase     <= 1'b0;
            out.valid <= 1'b0;
        end else begin
            if (in_accept) begin
                phase <= !phase && !in_last;
            end

            if (load_out) begin
                out.valid <= 1'b1;
            end else if (out.ready) begin
                out.valid <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Lane packing

    always_ff @(posedge clk) begin
        if (in_accept && !phase) begin
            lo_data <= in_data;
            lo_keep <= in_keep;
        end

        if (in_accept && phase) begin
            // Second beat goes to the upper lane
            out.data <= {in_data, lo_data};
            out.keep <= {in_keep, lo_keep};
            out.last <= in_last;
        end else if (in_accept && in_last) begin
            // Odd beat count flushes with upper keep cleared
            out.data <= {port_data_t'(0), in_data};
            out.keep <= {port_keep_t'(0), in_keep};
            out.last <= 1'b1;
        end
    end

endmodule

/* design/mpls_bus_pkg.sv */
/*
 * MPLS bus widths and vector types
 */

package mpls_bus_pkg;

    ////////////////////////////////////////
    // Byte lanes

    localparam int BYTE_BITS = 8;

    // Physical ingress port beat
    localparam int PORT_BYTES = 2;

    // Converged bus beat of two port beats
    localparam int CONV_BYTES = 4;

    ////////////////////////////////////////
    // Port side vectors

    typedef logic [PORT_BYTES*BYTE_BITS-1:0] port_data_t;
    typedef logic [PORT_BYTES-1:0]           port_keep_t;

    ////////////////////////////////////////
    // Converged side vectors

    typedef logic [CONV_BYTES*BYTE_BITS-1:0] conv_data_t;
    typedef logic [CONV_BYTES-1:0]           conv_keep_t;

endpackage

/* design/mpls_ingress_pkg.sv */
/*
 * MPLS ingress sizing and types
 */

package mpls_ingress_pkg;

    // Physical ingress ports merged by the arbiter
    localparam int NUM_PORTS = 4;

    // Largest frame for this build
    localparam int MTU_BYTES = 64;

    // Room for two MTUs of converged words
    localparam int FIFO_DEPTH     = MTU_BYTES * 2 / mpls_bus_pkg::CONV_BYTES;
    localparam int FIFO_ADDR_BITS = $clog2(FIFO_DEPTH);

    // Extra msb tells full from empty
    typedef logic [FIFO_ADDR_BITS:0] fifo_ptr_t;

    typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;

    // Frame level grant FSM
    typedef enum logic {
        ARB_IDLE,
        ARB_FRAME
    } arb_state_t;

endpackage

/* design/mpls_ingress_port_array.sv */
/*
 * MPLS ingress port array
 */

`timescale 1ns/10ps

module mpls_ingress_port_array (
    input  logic                                                       clk,
    input  logic                                                       rst,
    input  mpls_bus_pkg::port_data_t [mpls_ingress_pkg::NUM_PORTS-1:0] ing_tdata,
    input  mpls_bus_pkg::port_keep_t [mpls_ingress_pkg::NUM_PORTS-1:0] ing_tkeep,
    input  logic [mpls_ingress_pkg::NUM_PORTS-1:0]                     ing_tlast,
    input  logic [mpls_ingress_pkg::NUM_PORTS-1:0]                     ing_tvalid,
    output logic [mpls_ingress_pkg::NUM_PORTS-1:0]                     ing_tready,
    output logic [mpls_ingress_pkg::NUM_PORTS-1:0]                     ing_buf_overflow,
    output mpls_bus_pkg::conv_data_t                                   conv_tdata,
    output mpls_bus_pkg::conv_keep_t                                   conv_tkeep,
    output logic                                                       conv_tlast,
    output logic                                                       conv_tvalid,
    input  logic                                                       conv_tready,
    output mpls_ingress_pkg::port_idx_t                                conv_port
);
    import mpls_ingress_pkg::*;

    // Upsizer to buffer, then buffer to arbiter
    axis_if up_bus  [NUM_PORTS] ();
    axis_if buf_bus [NUM_PORTS] ();

    ////////////////////////////////////////
    // Per port adapt path

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        ing_width_upsizer u_upsizer (
            .clk      (clk),
            .rst      (rst),
            .in_data  (ing_tdata[i]),
            .in_keep  (ing_tkeep[i]),
            .in_last  (ing_tlast[i]),
            .in_valid (ing_tvalid[i]),
            .in_ready (ing_tready[i]),
            .out      (up_bus[i])
        );

        // Drops whole frames when full
        ing_frame_fifo u_fifo (
            .clk      (clk),
            .rst      (rst),
            .wr       (up_bus[i]),
            .rd       (buf_bus[i]),
            .overflow (ing_buf_overflow[i])
        );
    end

    ////////////////////////////////////////
    // Converged output

    ing_port_arbiter u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .ports_in    (buf_bus),
        .conv_tdata  (conv_tdata),
        .conv_tkeep  (conv_tkeep),
        .conv_tlast  (conv_tlast),
        .conv_tvalid (conv_tvalid),
        .conv_tready (conv_tready),
        .conv_port   (conv_port)
    );

endmodule

/* verification/tb_mpls_ingress.sv */
/*
 * MPLS ingress testbench
 */

`timescale 1ns/10ps

module tb_mpls_ingress;
    import mpls_bus_pkg::*;
    import mpls_ingress_pkg::*;

    // Five tests of under about 2000 cycles each
    localparam int TIMEOUT_CYCLES  = 20000;
    localparam int EXP_DEPTH       = 1024;
    localparam int FRAMES_PER_PORT = 3;
    // Three frames of this size stay within one buffer
    localparam int BURST_MAX_BYTES = 40;

    logic                       clk;
    logic                       rst;
    port_data_t [NUM_PORTS-1:0] ing_tdata;
    port_keep_t [NUM_PORTS-1:0] ing_tkeep;
    logic [NUM_PORTS-1:0]       ing_tlast;
    logic [NUM_PORTS-1:0]       ing_tvalid;
    logic [NUM_PORTS-1:0]       ing_tready;
    logic [NUM_PORTS-1:0]       ing_buf_overflow;
    conv_data_t                 conv_tdata;
    conv_keep_t                 conv_tkeep;
    logic                       conv_tlast;
    logic                       conv_tvalid;
    logic                       conv_tready;
    port_idx_t                  conv_port;

    // Expected converged beats per port as {last, keep, data}
    logic [36:0] exp_mem [NUM_PORTS*EXP_DEPTH];
    int          exp_head [NUM_PORTS];
    int          exp_tail [NUM_PORTS];
    logic [7:0]  frame_bytes [NUM_PORTS*MTU_BYTES];
    int          ovf_count [NUM_PORTS];

    integer    seed;
    string     cur_test;
    int        cycle_count;
    int        ready_mode;  // 0 low, 1 high, 2 random
    logic      in_frame;
    port_idx_t frame_port;

    mpls_ingress_port_array u_dut (.*);

    always #10 clk = ~clk;

    ////////////////////////////////////////
    // Checking

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic compare_value(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
        if (expected !== actual) begin
            stop_run($sformatf("ERROR %s: %s expected 0x%0h actual 0x%0h",
                               cur_test, what, expected, actual));
        end
    endtask

    task automatic check_beat(input port_idx_t port);
        logic [36:0] exp;
        if (exp_head[port] == exp_tail[port]) begin
            stop_run($sformatf("Beat from port %0d arrived with no frame pending", port));
        end else begin
            exp = exp_mem[int'(port) * EXP_DEPTH + exp_head[port]];
            exp_head[port]++;
            compare_value("data", exp[31:0], conv_tdata);
            compare_value("keep", exp[35:32], conv_tkeep);
            compare_value("last", exp[36], conv_tlast);
        end
    endtask

    function automatic int pending_beats();
        int total;
        total = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            total += exp_tail[p] - exp_head[p];
        end
        return total;
    endfunction

    // Converged bus monitor checking that the port holds until last
    always @(posedge clk) begin
        if (!rst && conv_tvalid && conv_tready) begin
            if (in_frame) begin
                compare_value("frame port", frame_port, conv_port);
            end
            check_beat(conv_port);
            in_frame   = !conv_tlast;
            frame_port = conv_port;
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (!rst && ing_buf_overflow[p]) begin
                ovf_count[p]++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_run($sformatf("Timeout after %0d cycles", cycle_count));
        end
    end

    always @(posedge clk) begin
        case (ready_mode)
            0:       conv_tready <= 1'b0;
            1:       conv_tready <= 1'b1;
            default: conv_tready <= ($random(seed) & 1) != 0;
        endcase
    end

    ////////////////////////////////////////
    // Stimulus

    task automatic send_frame(input int port, input int len, input bit delivered);
        int         base;
        int         nwords;
        conv_data_t wdata;
        conv_keep_t wkeep;
        base = port * MTU_BYTES;
        for (int k = 0; k < len; k++) begin
            frame_bytes[base + k] = $random(seed);
        end
        // Bytes in order, four per word, keep filled from lane 0
        nwords = (len + CONV_BYTES - 1) / CONV_BYTES;
        for (int w = 0; w < nwords && delivered; w++) begin
            wdata = '0;
            wkeep = '0;
            for (int l = 0; l < CONV_BYTES; l++) begin
                if (w * CONV_BYTES + l < len) begin
                    wdata[BYTE_BITS*l +: BYTE_BITS] = frame_bytes[base + w * CONV_BYTES + l];
                    wkeep[l] = 1'b1;
                end
            end
            exp_mem[port * EXP_DEPTH + exp_tail[port]] = {w == nwords - 1, wkeep, wdata};
            exp_tail[port]++;
        end
        @(posedge clk);
        for (int b = 0; 2 * b < len; b++) begin
            ing_tdata[port]  <= {(2 * b + 1 < len) ? frame_bytes[base + 2 * b + 1] : 8'h00,
                                 frame_bytes[base + 2 * b]};
            ing_tkeep[port]  <= (2 * b + 1 < len) ? 2'b11 : 2'b01;
            ing_tlast[port]  <= (2 * b + 2 >= len);
            ing_tvalid[port] <= 1'b1;
            do @(posedge clk); while (!ing_tready[port]);
        end
        ing_tvalid[port] <= 1'b0;
        ing_tlast[port]  <= 1'b0;
    endtask

    task automatic send_random_frames(input int port);
        int len;
        for (int i = 0; i < FRAMES_PER_PORT; i++) begin
            len = 1 + ({$random(seed)} % BURST_MAX_BYTES);
            send_frame(port, len, 1'b1);
        end
    endtask

    task automatic wait_drain();
        do @(posedge clk); while (pending_beats() != 0);
        // No beat may follow the expected frames
        @(posedge clk);
        compare_value("idle bus valid", 0, conv_tvalid);
    endtask

    ////////////////////////////////////////
    // Tests

    task automatic test_single_frame();
        cur_test = "single_frame";
        ready_mode <= 1;
        send_frame(0, 16, 1'b1);
        wait_drain();
    endtask

    task automatic test_odd_lengths();
        cur_test = "odd_lengths";
        ready_mode <= 1;
        for (int i = 0; i < 4; i++) begin
            send_frame(2, 2 * i + 1, 1'b1);
        end
        wait_drain();
    endtask

    task automatic test_all_ports(input string name, input int mode);
        cur_test = name;
        ready_mode <= mode;
        fork
            send_random_frames(0);
            send_random_frames(1);
            send_random_frames(2);
            send_random_frames(3);
        join
        wait_drain();
        for (int p = 0; p < NUM_PORTS; p++) begin
            compare_value($sformatf("overflow pulses on port %0d", p), 0, ovf_count[p]);
        end
    endtask

    task automatic test_drop_when_full();
        int before_ovf;
        cur_test = "drop_when_full";
        ready_mode <= 0;
        before_ovf = ovf_count[1];
        send_frame(1, MTU_BYTES, 1'b1);
        send_frame(1, MTU_BYTES, 1'b1);
        // Buffer holds two MTUs, so this one is lost
        send_frame(1, 16, 1'b0);
        ready_mode <= 1;
        wait_drain();
        send_frame(1, 10, 1'b1);
        wait_drain();
        compare_value("overflow pulses on port 1", before_ovf + 1, ovf_count[1]);
    endtask

    initial begin
        seed        = 32'hf50391a2;
        clk         = 1'b0;
        rst         = 1'b1;
        ing_tdata   = '0;
        ing_tkeep   = '0;
        ing_tlast   = '0;
        ing_tvalid  = '0;
        conv_tready = 1'b0;
        ready_mode  = 0;
        cycle_count = 0;
        in_frame    = 1'b0;
        frame_port  = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            exp_head[p]  = 0;
            exp_tail[p]  = 0;
            ovf_count[p] = 0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        test_single_frame();
        test_odd_lengths();
        test_all_ports("all_ports", 1);
        test_all_ports("back_pressure", 2);
        test_drop_when_full();

        if (pending_beats() != 0) begin
            stop_run($sformatf("%0d expected beats never arrived", pending_beats()));
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

/* vlog.f */
design/mpls_bus_pkg.sv
design/mpls_ingress_pkg.sv
design/axis_if.sv
design/ing_width_upsizer.sv
design/ing_frame_fifo.sv
design/ing_port_arbiter.sv
design/mpls_ingress_port_array.sv
verification/tb_mpls_ingress.sv
